// ==== hdl/clkgen_pkg.sv ====
`default_nettype none

package clkgen_pkg;

    localparam int DELAY_W = 8;

    typedef logic [DELAY_W-1:0] delay_t;

    localparam delay_t DELAY_INIT = 8'd32;
    // keeps the cpu reset release after the run point
    localparam delay_t DELAY_MIN  = 8'd8;
    localparam delay_t DELAY_MAX  = 8'd255;

    // sequencer counts after the apu clock fall
    localparam delay_t SEVEN_COUNT = 8'd3;
    localparam delay_t RUN_COUNT   = 8'd7;

    typedef enum logic {
        DIV_EIGHT,
        DIV_SEVEN
    } divide_mode_e;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_ARMED,
        SEQ_COUNT,
        SEQ_DONE
    } seq_state_e;

    typedef struct packed {
        divide_mode_e apu_mode;
        logic         cpu_run;
        logic         cpu_reset_n;
    } seq_ctrl_t;

    typedef struct packed {
        logic console_n;
        logic up_n;
        logic dn_n;
    } panel_t;

    typedef struct packed {
        logic [7:0] leds;
        logic [3:0] col_n;
    } display_t;

    // digit 0..15, column 0..3, each column a 4-bit pattern
    localparam logic [0:15][0:3][3:0] GLYPHS = {
        16'hEAAE, 16'h4444, 16'hC24E, 16'hC62C,
        16'hAAE2, 16'hE86E, 16'h8EAE, 16'hE222,
        16'hEAEE, 16'hEAE2, 16'hEAEA, 16'h8EAE,
        16'hE88E, 16'hCAAC, 16'hEC8E, 16'hE8E8
    };

endpackage

`default_nettype wire

// ==== hdl/tick_divider.sv ====
`default_nettype none
`timescale 1ns/100ps

module tick_divider #(
    parameter int TICK_DIV = 20000
) (
    input  logic clk,
    input  logic reset,
    output logic tick
);

    localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [CNT_W-1:0] count;
    logic             wrap;

    assign wrap = (count == CNT_W'(TICK_DIV - 1));

    always_ff @(posedge clk) begin
        if (!reset) begin
            count <= '0;
            tick  <= 1'b0;
        end else begin
            tick <= wrap;
            if (wrap) begin
                count <= '0;
            end else begin
                count <= count + CNT_W'(1);
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/button_debounce.sv ====
`default_nettype none
`timescale 1ns/100ps

module button_debounce #(
    parameter int DEBOUNCE_TICKS = 21
) (
    input  logic clk,
    input  logic reset,
    input  logic tick,
    input  logic raw,
    output logic clean
);

    localparam int CNT_W = (DEBOUNCE_TICKS > 1) ? $clog2(DEBOUNCE_TICKS) : 1;

    logic [CNT_W-1:0] tick_count;
    logic             sample;

    // sample index 0 of every window
    assign sample = (tick_count == '0);

    always_ff @(posedge clk) begin
        if (!reset) begin
            tick_count <= '0;
            clean      <= 1'b1;
        end else if (tick) begin
            if (sample) begin
                clean <= raw;
            end
            if (tick_count == CNT_W'(DEBOUNCE_TICKS - 1)) begin
                tick_count <= '0;
            end else begin
                tick_count <= tick_count + CNT_W'(1);
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/delay_setting.sv ====
`default_nettype none
`timescale 1ns/100ps

module delay_setting import clkgen_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  panel_t buttons,
    output delay_t delay
);

    logic up_prev;
    logic dn_prev;
    logic up_press;
    logic dn_press;

    // press is a falling edge of the debounced level
    assign up_press = up_prev && !buttons.up_n;
    assign dn_press = dn_prev && !buttons.dn_n;

    always_ff @(posedge clk) begin
        if (!reset) begin
            up_prev <= 1'b1;
            dn_prev <= 1'b1;
            delay   <= DELAY_INIT;
        end else begin
            up_prev <= buttons.up_n;
            dn_prev <= buttons.dn_n;
            // up wins when both are pressed together
            if (up_press) begin
                if (delay < DELAY_MAX) begin
                    delay <= delay + delay_t'(1);
                end
            end else if (dn_press) begin
                if (delay > DELAY_MIN) begin
                    delay <= delay - delay_t'(1);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/phase_divider.sv ====
`default_nettype none
`timescale 1ns/100ps

module phase_divider import clkgen_pkg::*; #(
    parameter logic [2:0] START_PHASE = 3'd0
) (
    input  logic         clk,
    input  logic         reset,
    input  logic         enable,
    input  divide_mode_e mode,
    output logic         clk_out
);

    logic [2:0]   phase;
    divide_mode_e cur_mode;
    logic [2:0]   last_phase;
    logic [2:0]   low_len;

    // seven: 3 low then 4 high, eight: 4 low then 4 high
    always_comb begin
        if (cur_mode == DIV_SEVEN) begin
            last_phase = 3'd6;
            low_len    = 3'd3;
        end else begin
            last_phase = 3'd7;
            low_len    = 3'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            phase    <= START_PHASE;
            cur_mode <= DIV_EIGHT;
            clk_out  <= 1'b0;
        end else if (!enable) begin
            phase    <= START_PHASE;
            cur_mode <= mode;
            clk_out  <= 1'b0;
        end else begin
            clk_out <= (phase >= low_len);
            if (phase == last_phase) begin
                phase <= 3'd0;
                // new mode only at the period boundary
                cur_mode <= mode;
            end else begin
                phase <= phase + 3'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/sync_sequencer.sv ====
`default_nettype none
`timescale 1ns/100ps

module sync_sequencer import clkgen_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      console_n,
    input  logic      apu_sync_n,
    input  logic      apu_clk,
    input  delay_t    delay,
    output seq_ctrl_t ctrl
);

    seq_state_e   state;
    delay_t       count;
    logic         apu_clk_q;
    logic         sync_seen;
    logic         apu_fall;

    assign apu_fall = apu_clk_q && !apu_clk;

    always_ff @(posedge clk) begin
        if (!reset) begin
            apu_clk_q <= 1'b0;
        end else begin
            apu_clk_q <= apu_clk;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset || !console_n) begin
            state            <= SEQ_IDLE;
            count            <= '0;
            sync_seen        <= 1'b0;
            ctrl.apu_mode    <= DIV_EIGHT;
            ctrl.cpu_run     <= 1'b0;
            ctrl.cpu_reset_n <= 1'b0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    sync_seen <= 1'b0;
                    state     <= SEQ_ARMED;
                end
                SEQ_ARMED: begin
                    if (!apu_sync_n) begin
                        sync_seen <= 1'b1;
                    end
                    // start on the first apu clock fall after the sync
                    if (sync_seen && apu_fall) begin
                        count <= '0;
                        state <= SEQ_COUNT;
                    end
                end
                SEQ_COUNT: begin
                    count <= count + delay_t'(1);
                    if (count == SEVEN_COUNT) begin
                        ctrl.apu_mode <= DIV_SEVEN;
                    end
                    if (count == RUN_COUNT) begin
                        ctrl.cpu_run <= 1'b1;
                    end
                    if (count == delay) begin
                        ctrl.cpu_reset_n <= 1'b1;
                        state            <= SEQ_DONE;
                    end
                end
                SEQ_DONE: begin
                    // hold until the console reset drops
                    state <= SEQ_DONE;
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/hex_display.sv ====
`default_nettype none
`timescale 1ns/100ps

module hex_display import clkgen_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     tick,
    input  delay_t   delay,
    output display_t disp
);

    logic [1:0] col;
    logic [1:0] col_next;
    logic [3:0] hi_glyph;
    logic [3:0] lo_glyph;

    assign col_next = col + 2'd1;

    // patterns for the column about to be shown
    assign hi_glyph = GLYPHS[delay[7:4]][col_next];
    assign lo_glyph = GLYPHS[delay[3:0]][col_next];

    always_ff @(posedge clk) begin
        if (!reset) begin
            col        <= 2'd0;
            disp.leds  <= 8'hFF;
            disp.col_n <= 4'b1110;
        end else if (tick) begin
            col <= col_next;
            // column select and leds move together
            disp.col_n <= ~(4'b0001 << col_next);
            disp.leds  <= ~{hi_glyph, lo_glyph};
        end
    end

endmodule

`default_nettype wire

// ==== hdl/clkgen_top.sv ====
`default_nettype none
`timescale 1ns/100ps

module clkgen_top import clkgen_pkg::*; #(
    parameter int TICK_DIV       = 20000,
    parameter int DEBOUNCE_TICKS = 21
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     console_reset_n,
    input  logic     alt_reset_n,
    input  logic     apu_sync_n,
    input  logic     del_up_n,
    input  logic     del_dn_n,
    output logic     apu_clk,
    output logic     cpu_clk,
    output logic     apu_reset_n,
    output logic     cpu_reset_n,
    output display_t disp
);

    logic      tick;
    logic      console_clean;
    logic      up_clean;
    logic      dn_clean;
    panel_t    panel;
    delay_t    delay;
    seq_ctrl_t ctrl;

    tick_divider #(.TICK_DIV(TICK_DIV)) u_tick (
        .clk(clk), .reset(reset), .tick(tick)
    );

    // either reset button restarts the console
    button_debounce #(.DEBOUNCE_TICKS(DEBOUNCE_TICKS)) u_deb_console (
        .clk(clk), .reset(reset), .tick(tick),
        .raw(console_reset_n & alt_reset_n), .clean(console_clean)
    );

    button_debounce #(.DEBOUNCE_TICKS(DEBOUNCE_TICKS)) u_deb_up (
        .clk(clk), .reset(reset), .tick(tick), .raw(del_up_n), .clean(up_clean)
    );

    button_debounce #(.DEBOUNCE_TICKS(DEBOUNCE_TICKS)) u_deb_dn (
        .clk(clk), .reset(reset), .tick(tick), .raw(del_dn_n), .clean(dn_clean)
    );

    assign panel = '{console_n: console_clean, up_n: up_clean, dn_n: dn_clean};

    delay_setting u_delay (
        .clk(clk), .reset(reset), .buttons(panel), .delay(delay)
    );

    sync_sequencer u_seq (
        .clk(clk), .reset(reset), .console_n(panel.console_n), .apu_sync_n(apu_sync_n),
        .apu_clk(apu_clk), .delay(delay), .ctrl(ctrl)
    );

    phase_divider #(.START_PHASE(3'd0)) u_apu_div (
        .clk(clk), .reset(reset), .enable(1'b1), .mode(ctrl.apu_mode), .clk_out(apu_clk)
    );

    // cpu divider starts one phase in, so its first low lasts 4 clk from run
    phase_divider #(.START_PHASE(3'd1)) u_cpu_div (
        .clk(clk), .reset(reset), .enable(ctrl.cpu_run), .mode(DIV_EIGHT), .clk_out(cpu_clk)
    );

    hex_display u_disp (
        .clk(clk), .reset(reset), .tick(tick), .delay(delay), .disp(disp)
    );

    assign cpu_reset_n = ctrl.cpu_reset_n;

    always_ff @(posedge clk) begin
        if (!reset) begin
            apu_reset_n <= 1'b0;
        end else begin
            apu_reset_n <= console_reset_n;
        end
    end

endmodule

`default_nettype wire

// ==== tests/clkgen_sva.sv ====
`default_nettype none
`timescale 1ns/100ps

module sync_sequencer_sva import clkgen_pkg::*; (
    input logic       clk,
    input logic       reset,
    input seq_state_e state,
    input seq_ctrl_t  ctrl
);

    // cpu reset lifts only once its clock runs
    a_reset_after_run: assert property (@(posedge clk) disable iff (!reset)
        ctrl.cpu_reset_n |-> ctrl.cpu_run)
        else $error("cpu_reset_n high while cpu_run is low");

    a_run_after_seven: assert property (@(posedge clk) disable iff (!reset)
        ctrl.cpu_run |-> (ctrl.apu_mode == DIV_SEVEN))
        else $error("cpu_run high while the apu divides by 8");

    a_idle_clear: assert property (@(posedge clk) disable iff (!reset)
        (state == SEQ_IDLE) |-> (ctrl == '0))
        else $error("controls set while the sequencer is idle");

    a_reset_clear: assert property (@(posedge clk)
        !reset |=> (ctrl == '0))
        else $error("controls not cleared by reset");

endmodule

bind sync_sequencer sync_sequencer_sva u_sva (
    .clk(clk), .reset(reset), .state(state), .ctrl(ctrl)
);

`default_nettype wire

// ==== tests/tb_clkgen.sv ====
`default_nettype none
`timescale 1ns/100ps

module tb_clkgen import clkgen_pkg::*; ();

    localparam int TICK_DIV       = 4;
    localparam int DEBOUNCE_TICKS = 3;
    localparam int CLK_PERIOD     = 20;
    localparam int PRESS_CYC      = 2 * DEBOUNCE_TICKS * TICK_DIV;
    localparam int MAX_PRESSES    = 250;
    localparam int ROW_BUDGET     = 2 * MAX_PRESSES * PRESS_CYC + 1200;
    localparam int RUN_T          = int'(RUN_COUNT) + 2;
    localparam int N_ROWS         = 7;

    typedef struct packed {
        logic [8:0] ups;
        logic [8:0] dns;
        delay_t     exp_delay;
        logic       sync;
    } row_t;

    // delay starts at 32 and is clamped to 8..255 with ups applied before downs
    localparam row_t ROWS [N_ROWS] = '{
        '{9'd0,   9'd0,  8'd32,  1'b1},
        '{9'd3,   9'd0,  8'd35,  1'b0},
        '{9'd0,   9'd5,  8'd30,  1'b1},
        '{9'd0,   9'd25, 8'd8,   1'b1},
        '{9'd2,   9'd0,  8'd10,  1'b0},
        '{9'd250, 9'd0,  8'd255, 1'b1},
        '{9'd1,   9'd3,  8'd252, 1'b1}
    };

    logic     clk;
    logic     reset;
    logic     console_reset_n;
    logic     alt_reset_n;
    logic     apu_sync_n;
    logic     del_up_n;
    logic     del_dn_n;
    logic     apu_clk;
    logic     cpu_clk;
    logic     apu_reset_n;
    logic     cpu_reset_n;
    display_t disp;
    int       errors;
    int       checks;

    clkgen_top #(.TICK_DIV(TICK_DIV), .DEBOUNCE_TICKS(DEBOUNCE_TICKS)) DUT (
        .clk(clk), .reset(reset), .console_reset_n(console_reset_n),
        .alt_reset_n(alt_reset_n), .apu_sync_n(apu_sync_n), .del_up_n(del_up_n),
        .del_dn_n(del_dn_n), .apu_clk(apu_clk), .cpu_clk(cpu_clk),
        .apu_reset_n(apu_reset_n), .cpu_reset_n(cpu_reset_n), .disp(disp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(N_ROWS * ROW_BUDGET * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d cycles", N_ROWS * ROW_BUDGET);
        $display("Simulation finished: FAIL");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic press_button(input logic up);
        if (up) del_up_n = 1'b0;
        else del_dn_n = 1'b0;
        repeat (PRESS_CYC) @(negedge clk);
        del_up_n = 1'b1;
        del_dn_n = 1'b1;
        repeat (PRESS_CYC) @(negedge clk);
    endtask

    // leds must show the glyph column that col_n selects
    task automatic check_display(input delay_t exp);
        logic [1:0] col;
        logic [7:0] exp_leds;
        logic [3:0] seen;
        seen = 4'b0000;
        repeat (4 * TICK_DIV + 2) begin
            @(negedge clk);
            col = 2'd0;
            case (disp.col_n)
                4'b1110: col = 2'd0;
                4'b1101: col = 2'd1;
                4'b1011: col = 2'd2;
                4'b0111: col = 2'd3;
                default: begin
                    errors++;
                    $display("column select %b is not one-hot low", disp.col_n);
                end
            endcase
            seen = seen | ~disp.col_n;
            exp_leds = ~{GLYPHS[exp[7:4]][col], GLYPHS[exp[3:0]][col]};
            check_value("disp.leds", 32'(disp.leds), 32'(exp_leds));
        end
        // the scan must visit every column within four ticks
        check_value("disp.col_n columns seen", 32'(seen), 32'hF);
    endtask

    task automatic pulse_console(input logic use_alt);
        logic exp_apu_rst;
        // apu_reset_n only follows the main reset button
        exp_apu_rst = use_alt;
        if (use_alt) alt_reset_n = 1'b0;
        else console_reset_n = 1'b0;
        check_value("apu_reset_n", 32'(apu_reset_n), 32'd1);
        @(negedge clk);
        check_value("apu_reset_n", 32'(apu_reset_n), 32'(exp_apu_rst));
        repeat (PRESS_CYC - 1) @(negedge clk);
        check_value("cpu_clk", 32'(cpu_clk), 32'd0);
        check_value("cpu_reset_n", 32'(cpu_reset_n), 32'd0);
        console_reset_n = 1'b1;
        alt_reset_n     = 1'b1;
        check_value("apu_reset_n", 32'(apu_reset_n), 32'(exp_apu_rst));
        @(negedge clk);
        check_value("apu_reset_n", 32'(apu_reset_n), 32'd1);
        repeat (PRESS_CYC - 1) @(negedge clk);
    endtask

    task automatic measure_apu(input int exp_low, input int exp_high);
        int lows;
        int highs;
        lows  = 0;
        highs = 0;
        @(negedge clk);
        while (apu_clk !== 1'b0) @(negedge clk);
        while (apu_clk === 1'b0) @(negedge clk);
        while (apu_clk === 1'b1) begin
            highs++;
            @(negedge clk);
        end
        while (apu_clk === 1'b0) begin
            lows++;
            @(negedge clk);
        end
        check_value("apu_clk high cycles", 32'(highs), 32'(exp_high));
        check_value("apu_clk low cycles", 32'(lows), 32'(exp_low));
    endtask

    task automatic run_sync(input delay_t d);
        int   idle;
        int   t;
        logic prev;
        logic found;
        logic exp_clk;
        idle = int'($urandom % 16);
        repeat (idle) @(negedge clk);
        prev       = apu_clk;
        apu_sync_n = 1'b0;
        found      = 1'b0;
        // t counts negedges after E0 at the first apu_clk fall once sync is seen
        for (t = 0; t < 16 && !found; t++) begin
            @(negedge clk);
            apu_sync_n = 1'b1;
            found      = prev && !apu_clk;
            prev       = apu_clk;
        end
        if (!found) begin
            errors++;
            $display("no apu_clk fall was seen after the sync pulse");
        end else begin
            for (t = 0; t <= int'(d) + 18; t++) begin
                exp_clk = (t >= RUN_T) && (((t - RUN_T) % 8) >= 4);
                check_value("cpu_reset_n", 32'(cpu_reset_n), 32'(t >= int'(d) + 2));
                check_value("cpu_clk", 32'(cpu_clk), 32'(exp_clk));
                @(negedge clk);
            end
        end
    endtask

    initial begin
        errors          = 0;
        checks          = 0;
        reset           = 1'b0;
        console_reset_n = 1'b1;
        alt_reset_n     = 1'b1;
        apu_sync_n      = 1'b1;
        del_up_n        = 1'b1;
        del_dn_n        = 1'b1;
        void'($urandom(48));
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_value("apu_clk", 32'(apu_clk), 32'd0);
        check_value("cpu_clk", 32'(cpu_clk), 32'd0);
        check_value("apu_reset_n", 32'(apu_reset_n), 32'd0);
        check_value("cpu_reset_n", 32'(cpu_reset_n), 32'd0);
        check_value("disp.leds", 32'(disp.leds), 32'hFF);
        check_value("disp.col_n", 32'(disp.col_n), 32'hE);
        reset = 1'b1;

        // free-running divide-by-8 before any sync
        measure_apu(4, 4);
        check_value("cpu_clk", 32'(cpu_clk), 32'd0);
        check_value("cpu_reset_n", 32'(cpu_reset_n), 32'd0);

        for (int i = 0; i < N_ROWS; i++) begin
            repeat (ROWS[i].ups) press_button(1'b1);
            repeat (ROWS[i].dns) press_button(1'b0);
            check_display(ROWS[i].exp_delay);
            if (ROWS[i].sync) begin
                pulse_console(i[0]);
                run_sync(ROWS[i].exp_delay);
                measure_apu(3, 4);
            end
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
hdl/clkgen_pkg.sv
hdl/tick_divider.sv
hdl/button_debounce.sv
hdl/delay_setting.sv
hdl/phase_divider.sv
hdl/sync_sequencer.sv
hdl/hex_display.sv
hdl/clkgen_top.sv
tests/clkgen_sva.sv
tests/tb_clkgen.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the clock generator testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --top-module tb_clkgen \
    -Mdir "$OBJ" -o tb_clkgen -f vlog.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"./$OBJ/tb_clkgen" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
